/* ex_pkg.sv */
// ********************************************************************
// ex_pkg: shared definitions for the RV64I execute stage
// widths, base opcodes, unit function codes and stage structs
// ********************************************************************
package ex_pkg;

    localparam int XLEN   = 64;
    localparam int ILEN   = 32;
    localparam int REG_AW = 5;

    // base opcodes
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub / sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef enum logic [2:0] {
        CLS_NONE   = 3'd0,
        CLS_ALU    = 3'd1,
        CLS_ALU_W  = 3'd2,
        CLS_LOAD   = 3'd3,
        CLS_STORE  = 3'd4,
        CLS_BRANCH = 3'd5
    } ex_class_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_fn_e;

    // same coding as branch funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_fn_e;

    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } mem_size_e;

    typedef struct packed {
        logic              valid;
        logic [ILEN-1:0]   inst;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   op1;
        logic [XLEN-1:0]   op2;  // rs2 value or immediate
        logic              rd_we;
        logic [REG_AW-1:0] rd_addr;
    } ex_in_t;

    typedef struct packed {
        ex_class_e       cls;
        alu_fn_e         alu_fn;
        logic            use_shamt;
        logic [5:0]      shamt;
        br_fn_e          br_fn;
        mem_size_e       mem_size;
        logic [XLEN-1:0] imm_s;
        logic [XLEN-1:0] imm_b;
    } ex_ctrl_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } ex_wb_t;

    typedef struct packed {
        logic            ce;
        logic            we;
        mem_size_e       size;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } ex_mem_req_t;

    typedef struct packed {
        logic            jump;
        logic [XLEN-1:0] target;
    } ex_redirect_t;

endpackage

/* ex_decode.sv */
// ********************************************************************
// ex_decode: instruction field split and classification
// builds the control word for the ALU, AGU and branch units
// ********************************************************************
`timescale 1ns/1ns

module ex_decode import ex_pkg::*; (
    input  logic [ILEN-1:0] inst_i,
    output ex_ctrl_t        ctrl_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] imm_s12;
    logic [12:0] imm_b13;
    logic        f7_ok;
    logic        alt;
    logic        imm_sh_ok;
    logic        w_ok;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign imm_s12 = {inst_i[31:25], inst_i[11:7]};
    assign imm_b13 = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign f7_ok   = (funct7 == F7_BASE) || (funct7 == F7_ALT);
    assign alt     = funct7[5];

    // rv64 immediate shifts keep shamt[5] in bit 25
    assign imm_sh_ok = (inst_i[31:26] == F7_BASE[6:1]) ||
                       ((inst_i[31:26] == F7_ALT[6:1]) && (funct3 == 3'b101));
    // addw/subw, sllw, srlw/sraw
    assign w_ok = f7_ok && ((funct3 == 3'b000) || (funct3 == 3'b101) ||
                            ((funct3 == 3'b001) && !alt));

    function automatic alu_fn_e f3_fn(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            3'b000:  f3_fn = sel_alt ? SUB : ADD;
            3'b001:  f3_fn = SLL;
            3'b010:  f3_fn = SLT;
            3'b011:  f3_fn = SLTU;
            3'b100:  f3_fn = XOR;
            3'b101:  f3_fn = sel_alt ? SRA : SRL;
            3'b110:  f3_fn = OR;
            default: f3_fn = AND;
        endcase
    endfunction

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.cls      = CLS_NONE;
        ctrl_o.alu_fn   = ADD;
        ctrl_o.br_fn    = BEQ;
        ctrl_o.shamt    = inst_i[25:20];
        ctrl_o.mem_size = mem_size_e'(funct3[1:0]);
        ctrl_o.imm_s    = {{(XLEN-12){imm_s12[11]}}, imm_s12};
        ctrl_o.imm_b    = {{(XLEN-13){imm_b13[12]}}, imm_b13};
        case (opcode)
            OPC_OP_IMM: begin
                if (((funct3 != 3'b001) && (funct3 != 3'b101)) || imm_sh_ok) begin
                    ctrl_o.cls       = CLS_ALU;
                    ctrl_o.alu_fn    = f3_fn(funct3, (funct3 == 3'b101) && alt); // no subi
                    ctrl_o.use_shamt = (funct3 == 3'b001) || (funct3 == 3'b101);
                end
            end
            OPC_OP: begin
                if (funct7 == F7_MULDIV) begin
                    ctrl_o.cls = CLS_NONE; // no M extension
                end else if (f7_ok && (!alt || (funct3 == 3'b000) || (funct3 == 3'b101))) begin
                    ctrl_o.cls    = CLS_ALU;
                    ctrl_o.alu_fn = f3_fn(funct3, alt);
                end
            end
            OPC_OP_IMM_32: begin
                if ((funct3 == 3'b000) || w_ok) begin
                    ctrl_o.cls       = CLS_ALU_W;
                    ctrl_o.alu_fn    = f3_fn(funct3, (funct3 == 3'b101) && alt);
                    ctrl_o.use_shamt = (funct3 != 3'b000);
                end
            end
            OPC_OP_32: begin
                if (w_ok) begin
                    ctrl_o.cls    = CLS_ALU_W;
                    ctrl_o.alu_fn = f3_fn(funct3, alt);
                end
            end
            OPC_LOAD:   if (funct3 != 3'b111) ctrl_o.cls = CLS_LOAD;
            OPC_STORE:  if (!funct3[2]) ctrl_o.cls = CLS_STORE;
            OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin
                    ctrl_o.cls   = CLS_BRANCH;
                    ctrl_o.br_fn = br_fn_e'(funct3);
                end
            end
            default: ctrl_o.cls = CLS_NONE;
        endcase
    end

    // word class only ever carries add/sub and the shifts
    always_comb begin
        if (ctrl_o.cls == CLS_ALU_W) begin
            assert (ctrl_o.alu_fn inside {ADD, SUB, SLL, SRL, SRA})
                else $error("word class with alu fn %0d", ctrl_o.alu_fn);
        end
    end

endmodule

/* ex_alu.sv */
// ********************************************************************
// ex_alu: integer results for the writeback path
// 64-bit OP/OP-IMM and sign-extended word forms
// ********************************************************************
`timescale 1ns/1ns

module ex_alu import ex_pkg::*; (
    input  ex_ctrl_t        ctrl_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    output logic [XLEN-1:0] data_o
);

    logic [5:0]      sh;
    logic [4:0]      sh_w;
    logic            lt;
    logic            ltu;
    logic [XLEN-1:0] res64;
    logic [31:0]     a_w;
    logic [31:0]     b_w;
    logic [31:0]     res_w;

    // immediate shift amount or rs2[5:0]
    assign sh   = ctrl_i.use_shamt ? ctrl_i.shamt : op2_i[5:0];
    assign sh_w = sh[4:0];

    assign lt  = $signed(op1_i) < $signed(op2_i);
    assign ltu = op1_i < op2_i;

    assign a_w = op1_i[31:0];
    assign b_w = op2_i[31:0];

    always_comb begin
        case (ctrl_i.alu_fn)
            ADD: begin
                res64 = op1_i + op2_i;
            end
            SUB: begin
                res64 = op1_i - op2_i;
            end
            SLL: begin
                res64 = op1_i << sh;
            end
            SLT: begin
                res64 = {{(XLEN-1){1'b0}}, lt};
            end
            SLTU: begin
                res64 = {{(XLEN-1){1'b0}}, ltu};
            end
            XOR: begin
                res64 = op1_i ^ op2_i;
            end
            SRL: begin
                res64 = op1_i >> sh;
            end
            SRA: begin
                res64 = $signed(op1_i) >>> sh; // fills with bit 63
            end
            OR: begin
                res64 = op1_i | op2_i;
            end
            AND: begin
                res64 = op1_i & op2_i;
            end
            default: begin
                res64 = '0;
            end
        endcase
    end

    // 32-bit forms
    always_comb begin
        case (ctrl_i.alu_fn)
            ADD:     res_w = a_w + b_w;
            SUB:     res_w = a_w - b_w;
            SLL:     res_w = a_w << sh_w;
            SRL:     res_w = a_w >> sh_w;  // zero fill, then sext below
            SRA:     res_w = $signed(a_w) >>> sh_w;
            default: res_w = '0;
        endcase
    end

    always_comb begin
        case (ctrl_i.cls)
            CLS_ALU: begin
                data_o = res64;
            end
            CLS_ALU_W: begin
                data_o = {{(XLEN-32){res_w[31]}}, res_w};
            end
            default: begin
                data_o = '0; // loads get data from memory later
            end
        endcase
    end

endmodule

/* ex_branch.sv */
// ********************************************************************
// ex_branch: conditional branch compare and target
// ********************************************************************
`timescale 1ns/1ns

module ex_branch import ex_pkg::*; (
    input  ex_ctrl_t        ctrl_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    output ex_redirect_t    redir_o
);

    logic eq;
    logic lt;
    logic ltu;
    logic cond;
    logic take;

    assign eq  = (op1_i == op2_i);
    assign lt  = $signed(op1_i) < $signed(op2_i);
    assign ltu = op1_i < op2_i;

    always_comb begin
        case (ctrl_i.br_fn)
            BEQ:     cond = eq;
            BNE:     cond = !eq;
            BLT:     cond = lt;
            BGE:     cond = !lt;
            BLTU:    cond = ltu;
            BGEU:    cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign take = (ctrl_i.cls == CLS_BRANCH) && cond;

    always_comb begin
        redir_o.jump   = take;
        redir_o.target = take ? pc_i + ctrl_i.imm_b : '0; // zero when not taken
    end

endmodule

/* ex_agu.sv */
// ********************************************************************
// ex_agu: load/store address generation
// also formats store data to the access size
// ********************************************************************
`timescale 1ns/1ns

module ex_agu import ex_pkg::*; (
    input  ex_ctrl_t        ctrl_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    output ex_mem_req_t     req_o
);

    logic [XLEN-1:0] st_data;

    // zero-extend rs2 from the store width
    always_comb begin
        case (ctrl_i.mem_size)
            BYTE:    st_data = {{(XLEN-8){1'b0}}, op2_i[7:0]};
            HALF:    st_data = {{(XLEN-16){1'b0}}, op2_i[15:0]};
            WORD:    st_data = {{(XLEN-32){1'b0}}, op2_i[31:0]};
            default: st_data = op2_i;
        endcase
    end

    always_comb begin
        req_o = '0;
        case (ctrl_i.cls)
            CLS_LOAD: begin
                req_o.ce   = 1'b1;
                req_o.size = ctrl_i.mem_size;
                req_o.addr = op1_i + op2_i; // op2 holds the i-type offset
            end
            CLS_STORE: begin
                req_o.ce    = 1'b1;
                req_o.we    = 1'b1;
                req_o.size  = ctrl_i.mem_size;
                req_o.addr  = op1_i + ctrl_i.imm_s;
                req_o.wdata = st_data;
            end
            default: begin
                req_o = '0;
            end
        endcase
    end

endmodule

/* ex_stage.sv */
// ********************************************************************
// ex_stage: RV64I execute stage top
// decode, ALU, AGU and branch units with one output register
// ********************************************************************
`timescale 1ns/1ns

module ex_stage import ex_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,
    input  ex_in_t       in_i,
    output ex_wb_t       wb_o,
    output ex_mem_req_t  mem_o,
    output ex_redirect_t redir_o
);

    ex_ctrl_t        ctrl;
    logic [XLEN-1:0] alu_data;
    ex_mem_req_t     mem_req;
    ex_redirect_t    redir;
    ex_wb_t          wb;
    logic            wb_cls;
    ex_wb_t          wb_next;
    ex_mem_req_t     mem_next;
    ex_redirect_t    redir_next;

    ex_decode u_decode (
        .inst_i (in_i.inst),
        .ctrl_o (ctrl)
    );

    ex_alu u_alu (
        .ctrl_i (ctrl),
        .op1_i  (in_i.op1),
        .op2_i  (in_i.op2),
        .data_o (alu_data)
    );

    ex_agu u_agu (
        .ctrl_i (ctrl),
        .op1_i  (in_i.op1),
        .op2_i  (in_i.op2),
        .req_o  (mem_req)
    );

    ex_branch u_branch (
        .ctrl_i  (ctrl),
        .pc_i    (in_i.pc),
        .op1_i   (in_i.op1),
        .op2_i   (in_i.op2),
        .redir_o (redir)
    );

    assign wb_cls = ctrl.cls inside {CLS_ALU, CLS_ALU_W, CLS_LOAD};

    always_comb begin
        wb.we   = in_i.rd_we && wb_cls;
        wb.addr = wb.we ? in_i.rd_addr : '0;
        wb.data = alu_data; // alu gives zero for loads
    end

    // idle cycle drives all zeros
    always_comb begin
        wb_next    = '0;
        mem_next   = '0;
        redir_next = '0;
        if (in_i.valid) begin
            wb_next    = wb;
            mem_next   = mem_req;
            redir_next = redir;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o    <= '0;
            mem_o   <= '0;
            redir_o <= '0;
        end else begin
            wb_o    <= wb_next;
            mem_o   <= mem_next;
            redir_o <= redir_next;
        end
    end

    a_store_has_ce: assert property (@(posedge clk) disable iff (reset_i)
        mem_o.we |-> mem_o.ce)
        else $error("memory write without chip enable");

    // a taken branch neither writes back nor touches memory
    a_jump_no_wb: assert property (@(posedge clk) disable iff (reset_i)
        redir_o.jump |-> !wb_o.we)
        else $error("branch redirect with register writeback");

    a_jump_no_mem: assert property (@(posedge clk) disable iff (reset_i)
        redir_o.jump |-> !mem_o.ce)
        else $error("branch redirect with memory request");

endmodule

/* tb_ex_stage.sv */
// **********************************************************************
// tb_ex_stage drives the RV64I execute stage with directed tests
// and checks it against a reference model with one cycle latency
// **********************************************************************
`timescale 1ns/1ns

module tb_ex_stage import ex_pkg::*; ();

    localparam int N_RESET      = 6;
    localparam int N_ALU64      = 200;
    localparam int N_ALU_W      = 100;
    localparam int N_MEM        = 11;
    localparam int N_BRANCH     = 36;
    localparam int N_UNSUP      = 12;
    localparam int N_FLUSH      = 6;
    localparam int TOTAL_CYCLES = N_RESET + N_ALU64 + N_ALU_W + N_MEM + N_BRANCH + N_UNSUP
                                  + N_FLUSH;
    localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 100) * 10;

    logic         clk;
    logic         reset_i;
    ex_in_t       in_i;
    ex_wb_t       wb_o;
    ex_mem_req_t  mem_o;
    ex_redirect_t redir_o;

    ex_wb_t       exp_wb;
    ex_mem_req_t  exp_mem;
    ex_redirect_t exp_redir;
    int           n_checks;
    int           n_errors;

    ex_stage ex_stage_i (
        .clk     (clk),
        .reset_i (reset_i),
        .in_i    (in_i),
        .wb_o    (wb_o),
        .mem_o   (mem_o),
        .redir_o (redir_o)
    );

    always #5 clk = ~clk;

    function automatic logic [XLEN-1:0] rnd64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
        return {{(XLEN-12){v[11]}}, v};
    endfunction

    function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
        return {{(XLEN-32){v[31]}}, v};
    endfunction

    function automatic logic [ILEN-1:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'($urandom_range(1, 31)), opc};
    endfunction

    function automatic logic [ILEN-1:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                               input logic [6:0] opc);
        return {imm, 5'd1, f3, 5'($urandom_range(1, 31)), opc};
    endfunction

    function automatic logic [ILEN-1:0] s_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [ILEN-1:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic ex_in_t make_in(input logic [ILEN-1:0] inst, input logic [XLEN-1:0] op1,
                                       input logic [XLEN-1:0] op2);
        ex_in_t x;
        x.valid   = 1'b1;
        x.inst    = inst;
        x.pc      = rnd64() & ~64'd3;
        x.op1     = op1;
        x.op2     = op2;
        x.rd_we   = ($urandom_range(0, 3) != 0);
        x.rd_addr = inst[11:7];
        return x;
    endfunction

    // valid low with busy fields still gives zeros
    function automatic ex_in_t idle_in();
        ex_in_t x;
        x       = make_in(r_type(F7_BASE, 3'b110, OPC_OP), rnd64(), rnd64());
        x.valid = 1'b0;
        return x;
    endfunction

    // right shift with an optional fill of the vacated upper bits
    function automatic logic [XLEN-1:0] shr_fill(input logic [XLEN-1:0] a, input int sh,
                                                 input logic fill);
        logic [XLEN-1:0] r;
        r = a >> sh;
        if (fill) begin
            r = r | ~({XLEN{1'b1}} >> sh);
        end
        return r;
    endfunction

    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b, input int sh);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b011:  return (a < b) ? 64'd1 : 64'd0;
            3'b100:  return a ^ b;
            3'b101:  return shr_fill(a, sh, alt & a[63]);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // low 32 bits of the 64-bit op sign-extended from bit 31
    function automatic logic [XLEN-1:0] alu_w_ref(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b, input int sh);
        logic [XLEN-1:0] r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << sh;
            default: r = alt ? shr_fill(sext32(a[31:0]), sh, a[31])
                             : shr_fill({32'h0, a[31:0]}, sh, 1'b0);
        endcase
        return sext32(r[31:0]);
    endfunction

    function automatic logic [XLEN-1:0] size_mask(input logic [1:0] sz);
        case (sz)
            2'd0:    return 64'hff;
            2'd1:    return 64'hffff;
            2'd2:    return 64'hffff_ffff;
            default: return {XLEN{1'b1}};
        endcase
    endfunction

    function automatic void model(input ex_in_t x, output ex_wb_t wb, output ex_mem_req_t m,
                                  output ex_redirect_t r);
        logic [6:0]      opc;
        logic [6:0]      f7;
        logic [2:0]      f3;
        logic [12:0]     bimm;
        logic [XLEN-1:0] res;
        logic            alu_ok;
        logic            ld_ok;
        logic            cond;
        opc    = x.inst[6:0];
        f3     = x.inst[14:12];
        f7     = x.inst[31:25];
        bimm   = {x.inst[31], x.inst[7], x.inst[30:25], x.inst[11:8], 1'b0};
        wb     = '0;
        m      = '0;
        r      = '0;
        res    = '0;
        alu_ok = 1'b0;
        ld_ok  = 1'b0;
        cond   = 1'b0;
        case (opc)
            OPC_OP: begin
                alu_ok = (f7 == F7_BASE) || ((f7 == F7_ALT) && (f3 == 3'b000 || f3 == 3'b101));
                res    = alu_ref(f3, f7[5], x.op1, x.op2, int'(x.op2[5:0]));
            end
            OPC_OP_IMM: begin
                alu_ok = (x.inst[31:26] == 6'd0) || (f3 != 3'b001 && f3 != 3'b101) ||
                         ((f3 == 3'b101) && (x.inst[31:26] == 6'b010000));
                res    = alu_ref(f3, (f3 == 3'b101) && x.inst[30], x.op1, x.op2,
                                 int'(x.inst[25:20]));
            end
            OPC_OP_IMM_32: begin
                alu_ok = (f3 == 3'b000) || ((f3 == 3'b001) && (f7 == F7_BASE)) ||
                         ((f3 == 3'b101) && (f7 == F7_BASE || f7 == F7_ALT));
                res    = alu_w_ref(f3, (f3 == 3'b101) && f7[5], x.op1, x.op2,
                                   int'(x.inst[24:20]));
            end
            OPC_OP_32: begin
                alu_ok = ((f3 == 3'b000 || f3 == 3'b101) && (f7 == F7_BASE || f7 == F7_ALT)) ||
                         ((f3 == 3'b001) && (f7 == F7_BASE));
                res    = alu_w_ref(f3, f7[5], x.op1, x.op2, int'(x.op2[4:0]));
            end
            OPC_LOAD: begin
                if (f3 != 3'b111) begin
                    ld_ok  = 1'b1;
                    m.ce   = 1'b1;
                    m.size = mem_size_e'(f3[1:0]);
                    m.addr = x.op1 + x.op2;
                end
            end
            OPC_STORE: begin
                if (!f3[2]) begin
                    m.ce    = 1'b1;
                    m.we    = 1'b1;
                    m.size  = mem_size_e'(f3[1:0]);
                    m.addr  = x.op1 + sext12({x.inst[31:25], x.inst[11:7]});
                    m.wdata = x.op2 & size_mask(f3[1:0]);
                end
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  cond = (x.op1 == x.op2);
                    3'b001:  cond = (x.op1 != x.op2);
                    3'b100:  cond = ($signed(x.op1) < $signed(x.op2));
                    3'b101:  cond = ($signed(x.op1) >= $signed(x.op2));
                    3'b110:  cond = (x.op1 < x.op2);
                    3'b111:  cond = (x.op1 >= x.op2);
                    default: cond = 1'b0;
                endcase
                if (cond) begin
                    r.jump   = 1'b1;
                    r.target = x.pc + {{(XLEN-13){bimm[12]}}, bimm};
                end
            end
            default: begin
                alu_ok = 1'b0; // unsupported opcode
            end
        endcase
        if (alu_ok || ld_ok) begin
            wb.we   = x.rd_we;
            wb.addr = x.rd_we ? x.rd_addr : '0;
            wb.data = alu_ok ? res : '0;
        end
        if (!x.valid) begin
            wb = '0;
            m  = '0;
            r  = '0;
        end
    endfunction

    task automatic check_wb(input ex_wb_t got, input ex_wb_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("ERROR t=%0t wb_o: got %h expected %h", $time, got, want);
        end
    endtask

    task automatic check_mem(input ex_mem_req_t got, input ex_mem_req_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("ERROR t=%0t mem_o: got %h expected %h", $time, got, want);
        end
    endtask

    task automatic check_redir(input ex_redirect_t got, input ex_redirect_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("ERROR t=%0t redir_o: got %h expected %h", $time, got, want);
        end
    endtask

    // checks the previous input's result before applying the next one
    task automatic drive(input ex_in_t x, input logic expect_none);
        @(negedge clk);
        check_wb(wb_o, exp_wb);
        check_mem(mem_o, exp_mem);
        check_redir(redir_o, exp_redir);
        in_i = x;
        model(x, exp_wb, exp_mem, exp_redir);
        if (expect_none) begin
            exp_wb    = '0;
            exp_mem   = '0;
            exp_redir = '0;
        end
    endtask

    task automatic finish_test(input string name, input int c0, input int e0);
        drive(idle_in(), 1'b1);
        $display("%s: %0d checks, %0d errors", name, n_checks - c0, n_errors - e0);
    endtask

    task automatic reset_sequence();
        int c0;
        int e0;
        c0      = n_checks;
        e0      = n_errors;
        in_i    = make_in(r_type(F7_BASE, 3'b000, OPC_OP), 64'd1, 64'd2);
        reset_i = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_wb(wb_o, '0);
            check_mem(mem_o, '0);
            check_redir(redir_o, '0);
        end
        reset_i = 1'b0;
        in_i    = idle_in();
        model(in_i, exp_wb, exp_mem, exp_redir);
        repeat (2) drive(idle_in(), 1'b1);
        finish_test("reset", c0, e0);
    endtask

    task automatic alu64_stream();
        int              c0;
        int              e0;
        logic [2:0]      f3;
        logic            alt;
        logic [5:0]      sh;
        logic [11:0]     imm;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        c0 = n_checks;
        e0 = n_errors;
        for (int i = 0; i < N_ALU64; i++) begin
            f3  = 3'($urandom_range(0, 7));
            a   = rnd64();
            b   = rnd64();
            sh  = 6'($urandom_range(0, 63));
            alt = (f3 == 3'b000 || f3 == 3'b101) && ($urandom_range(0, 1) == 1);
            if (i % 8 < 2) begin // sra/srai with bit 63 set and shift 0 or 63
                f3     = 3'b101;
                alt    = 1'b1;
                a[63]  = 1'b1;
                sh     = (i % 16 < 8) ? 6'd0 : 6'd63;
                b[5:0] = sh;
            end
            if (i % 2 == 0) begin
                drive(make_in(r_type(alt ? F7_ALT : F7_BASE, f3, OPC_OP), a, b), 1'b0);
            end else begin
                imm = 12'($urandom);
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {1'b0, alt && (f3 == 3'b101), 4'b0000, sh};
                end
                drive(make_in(i_type(imm, f3, OPC_OP_IMM), a, sext12(imm)), 1'b0);
            end
        end
        finish_test("alu64", c0, e0);
    endtask

    task automatic word_alu_stream();
        int              c0;
        int              e0;
        int              k;
        logic [4:0]      sh5;
        logic [11:0]     imm;
        logic [ILEN-1:0] inst;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        c0 = n_checks;
        e0 = n_errors;
        for (int i = 0; i < N_ALU_W; i++) begin
            k   = i % 8;
            a   = rnd64();
            b   = rnd64();
            sh5 = (i < 8) ? 5'd0 : 5'($urandom);
            imm = 12'($urandom);
            if (i < 16) begin // bit 31 set and addw overflow
                a[31] = 1'b1;
                if (k == 0 || k == 5) begin
                    a[31:0] = 32'h7fff_ffff;
                    b[31:0] = 32'd1;
                    imm     = 12'd1;
                end
            end
            if (i < 8) begin
                b[4:0] = 5'd0;
            end
            case (k)
                0: inst = r_type(F7_BASE, 3'b000, OPC_OP_32);
                1: inst = r_type(F7_ALT, 3'b000, OPC_OP_32);
                2: inst = r_type(F7_BASE, 3'b001, OPC_OP_32);
                3: inst = r_type(F7_BASE, 3'b101, OPC_OP_32);
                4: inst = r_type(F7_ALT, 3'b101, OPC_OP_32);
                5: begin
                    inst = i_type(imm, 3'b000, OPC_OP_IMM_32);
                    b    = sext12(imm);
                end
                6: inst = i_type({7'b0, sh5}, (i % 16 == 6) ? 3'b001 : 3'b101, OPC_OP_IMM_32);
                default: inst = i_type({F7_ALT, sh5}, 3'b101, OPC_OP_IMM_32);
            endcase
            drive(make_in(inst, a, b), 1'b0);
        end
        finish_test("alu_w", c0, e0);
    endtask

    task automatic mem_requests();
        int          c0;
        int          e0;
        logic [11:0] imm;
        c0 = n_checks;
        e0 = n_errors;
        for (int f = 0; f < 7; f++) begin
            imm = 12'($urandom);
            drive(make_in(i_type(imm, 3'(f), OPC_LOAD), rnd64(), sext12(imm)), 1'b0);
        end
        for (int f = 0; f < 4; f++) begin
            imm = 12'($urandom);
            drive(make_in(s_type(imm, 3'(f)), rnd64(), rnd64()), 1'b0);
        end
        finish_test("mem", c0, e0);
    endtask

    task automatic branch_pairs();
        int              c0;
        int              e0;
        logic [12:0]     imm13;
        logic [XLEN-1:0] pa [6];
        logic [XLEN-1:0] pb [6];
        c0 = n_checks;
        e0 = n_errors;
        // equal and unequal pairs then signed versus unsigned corners
        pa = '{64'd5, 64'd5, {XLEN{1'b1}}, 64'd1, 64'h8000_0000_0000_0000,
               64'h7fff_ffff_ffff_ffff};
        pb = '{64'd5, 64'd6, 64'd1, {XLEN{1'b1}}, 64'h7fff_ffff_ffff_ffff,
               64'h8000_0000_0000_0000};
        for (int j = 0; j < 6; j++) begin
            for (int p = 0; p < 6; p++) begin
                imm13 = 13'($urandom) & 13'h1ffe;
                drive(make_in(b_type(imm13, 3'((j < 2) ? j : j + 2)), pa[p], pb[p]), 1'b0);
            end
        end
        finish_test("branch", c0, e0);
    endtask

    task automatic unsupported_mix();
        int              c0;
        int              e0;
        logic [ILEN-1:0] bad [6];
        c0     = n_checks;
        e0     = n_errors;
        bad[0] = r_type(F7_MULDIV, 3'b000, OPC_OP);    // mul
        bad[1] = r_type(F7_MULDIV, 3'b100, OPC_OP);    // div
        bad[2] = r_type(F7_MULDIV, 3'b000, OPC_OP_32); // mulw
        bad[3] = r_type(F7_MULDIV, 3'b111, OPC_OP_32); // remuw
        bad[4] = {25'h0abcde, 7'b0110111};             // lui
        bad[5] = {25'h1234, 7'b1111111};
        for (int i = 0; i < 6; i++) begin
            drive(make_in(r_type(F7_BASE, 3'($urandom), OPC_OP), rnd64(), rnd64()), 1'b0);
            drive(make_in(bad[i], rnd64(), rnd64()), 1'b1);
        end
        finish_test("unsupported", c0, e0);
    endtask

    initial begin
        void'($urandom(28));
        clk      = 1'b0;
        reset_i  = 1'b1;
        in_i     = '0;
        n_checks = 0;
        n_errors = 0;
        reset_sequence();
        alu64_stream();
        word_alu_stream();
        mem_requests();
        branch_pairs();
        unsupported_mix();
        drive(idle_in(), 1'b1); // picks up the last pending result
        $display("checks passed: %0d, failed: %0d", n_checks - n_errors, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: tests did not complete within %0d ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* project.f */
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_branch.sv
ex_agu.sv
ex_stage.sv
tb_ex_stage.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
PASS_MSG  := RESULT: PASS

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
